// File: verilog/busCpu_consts.svh
`ifndef BUSCPU_CONSTS_SVH
`define BUSCPU_CONSTS_SVH

// Datapath sizes
`define WORD_W      32
`define NUM_REGS    16
`define NUM_SRCS    (`NUM_REGS + 8)  // General registers plus the eight other bus sources
`define IMM_W       19               // Immediate field at the bottom of IR

// ALU operation codes
`define OPCODE_W    5
`define OP_AND      5'b00011
`define OP_ADD      5'b00100
`define OP_SUB      5'b00101
`define OP_OR       5'b00110
`define OP_SHR      5'b00111
`define OP_SHL      5'b01000
`define OP_ROR      5'b01001
`define OP_ROL      5'b01010
`define OP_MUL      5'b01011
`define OP_NEG      5'b01100
`define OP_NOT      5'b01101
`define OP_NOP      5'b11010

`endif

// File: verilog/busCpuPkg.sv
`include "busCpu_consts.svh"

package busCpuPkg;

    typedef logic [`WORD_W-1:0]   word_t;    // One bus or register word
    typedef logic [`OPCODE_W-1:0] opcode_t;  // ALU operation select

    // Bus source strobes, at most one high per cycle
    typedef struct packed {
        logic [`NUM_REGS-1:0] rOut;
        logic                 hiOut;
        logic                 loOut;
        logic                 zHighOut;
        logic                 zLowOut;
        logic                 pcOut;
        logic                 mdrOut;
        logic                 inPortOut;
        logic                 cOut;       // Sign-extended immediate from IR
    } busSrc_t;

    // Register load strobes, any number may be high
    typedef struct packed {
        logic [`NUM_REGS-1:0] rIn;
        logic                 hiIn;
        logic                 loIn;
        logic                 pcIn;
        logic                 irIn;
        logic                 marIn;
        logic                 mdrIn;
        logic                 yIn;
        logic                 zIn;
        logic                 read;       // MDR takes memory data instead of the bus
        logic                 incPc;      // Forces the ALU to bus plus one
    } regLoad_t;

endpackage

// File: verilog/regFile.sv
`timescale 1ns/10ps
`include "busCpu_consts.svh"

module regFile (
    input  logic                 clock,
    input  logic                 rst,
    input  busCpuPkg::word_t     busWord,
    input  busCpuPkg::regLoad_t  regLoad,
    output busCpuPkg::word_t     regs [`NUM_REGS],
    output busCpuPkg::word_t     hi,
    output busCpuPkg::word_t     lo
);

    // R0 to R15, each with its own load strobe
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                if (regLoad.rIn[i]) begin
                    regs[i] <= busWord;
                end
            end
        end
    end

    // HI half of a product or remainder
    always_ff @(posedge clock) begin
        if (rst) begin
            hi <= '0;
        end else if (regLoad.hiIn) begin
            hi <= busWord;
        end
    end

    // LO half
    always_ff @(posedge clock) begin
        if (rst) begin
            lo <= '0;
        end else if (regLoad.loIn) begin
            lo <= busWord;
        end
    end

endmodule

// File: verilog/busMux.sv
`timescale 1ns/10ps
`include "busCpu_consts.svh"

module busMux (
    input  busCpuPkg::busSrc_t busSrc,
    input  busCpuPkg::word_t   regs [`NUM_REGS],
    input  busCpuPkg::word_t   hi,
    input  busCpuPkg::word_t   lo,
    input  busCpuPkg::word_t   zHigh,
    input  busCpuPkg::word_t   zLow,
    input  busCpuPkg::word_t   pc,
    input  busCpuPkg::word_t   mdr,
    input  busCpuPkg::word_t   inPortData,
    input  busCpuPkg::word_t   ir,
    output busCpuPkg::word_t   busWord
);
    import busCpuPkg::*;

    word_t                srcWords [`NUM_SRCS];
    logic [`NUM_SRCS-1:0] srcFlat;  // Bit 0 is R0out, top bit is cOut
    logic [4:0]           srcSel;
    logic                 srcAny;
    word_t                immExt;

    assign immExt = {{(`WORD_W - `IMM_W){ir[`IMM_W-1]}}, ir[`IMM_W-1:0]};

    // Strobes in priority order, highest priority at bit 0
    assign srcFlat = {busSrc.cOut, busSrc.inPortOut, busSrc.mdrOut, busSrc.pcOut,
                      busSrc.zLowOut, busSrc.zHighOut, busSrc.loOut, busSrc.hiOut,
                      busSrc.rOut};

    // Candidate words, same indexing as srcFlat
    always_comb begin
        for (int i = 0; i < `NUM_REGS; i++) begin
            srcWords[i] = regs[i];
        end
        srcWords[`NUM_REGS]     = hi;
        srcWords[`NUM_REGS + 1] = lo;
        srcWords[`NUM_REGS + 2] = zHigh;
        srcWords[`NUM_REGS + 3] = zLow;
        srcWords[`NUM_REGS + 4] = pc;
        srcWords[`NUM_REGS + 5] = mdr;
        srcWords[`NUM_REGS + 6] = inPortData;
        srcWords[`NUM_REGS + 7] = immExt;
    end

    // Priority encoder, scanning down so the lowest set bit wins
    always_comb begin
        srcSel = '0;
        srcAny = 1'b0;
        for (int i = `NUM_SRCS - 1; i >= 0; i--) begin
            if (srcFlat[i]) begin
                srcSel = 5'(i);
                srcAny = 1'b1;
            end
        end
    end

    assign busWord = srcAny ? srcWords[srcSel] : '0;  // Idle bus reads zero

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/10ps
`include "busCpu_consts.svh"

module aluUnit (
    input  logic                clock,
    input  logic                rst,
    input  busCpuPkg::word_t    busWord,
    input  busCpuPkg::opcode_t  opcode,
    input  busCpuPkg::regLoad_t regLoad,
    output busCpuPkg::word_t    zHigh,
    output busCpuPkg::word_t    zLow
);
    import busCpuPkg::*;

    word_t                    yReg;     // Operand A
    logic [4:0]               shAmt;
    logic [2*`WORD_W-1:0]     rorWide;
    logic [2*`WORD_W-1:0]     rolWide;
    logic signed [2*`WORD_W-1:0] product;
    word_t                    lowWord;
    word_t                    highWord;
    logic [2*`WORD_W-1:0]     zReg;

    // Y latch holds the first operand while B sits on the bus
    always_ff @(posedge clock) begin
        if (rst) begin
            yReg <= '0;
        end else if (regLoad.yIn) begin
            yReg <= busWord;
        end
    end

    assign shAmt = busWord[4:0];  // Shift amount from B

    // Rotates through a doubled copy of A
    assign rorWide = {yReg, yReg} >> shAmt;
    assign rolWide = {yReg, yReg} << shAmt;

    assign product = $signed(yReg) * $signed(busWord);

    always_comb begin
        highWord = '0;  // Only multiply fills the high word
        lowWord  = '0;
        if (regLoad.incPc) begin
            lowWord = busWord + word_t'(1);
        end else begin
            case (opcode)
                `OP_AND: lowWord = yReg & busWord;
                `OP_ADD: lowWord = yReg + busWord;
                `OP_SUB: lowWord = yReg - busWord;
                `OP_OR:  lowWord = yReg | busWord;
                `OP_SHR: lowWord = yReg >> shAmt;   // Logical
                `OP_SHL: lowWord = yReg << shAmt;
                `OP_ROR: lowWord = rorWide[`WORD_W-1:0];
                `OP_ROL: lowWord = rolWide[2*`WORD_W-1:`WORD_W];
                `OP_MUL: begin
                    lowWord  = product[`WORD_W-1:0];
                    highWord = product[2*`WORD_W-1:`WORD_W];
                end
                `OP_NEG: lowWord = -busWord;        // Unary ops work on B
                `OP_NOT: lowWord = ~busWord;
                `OP_NOP: lowWord = '0;
                default: lowWord = '0;
            endcase
        end
    end

    // Z result register, high and low words read separately
    always_ff @(posedge clock) begin
        if (rst) begin
            zReg <= '0;
        end else if (regLoad.zIn) begin
            zReg <= {highWord, lowWord};
        end
    end

    assign zHigh = zReg[2*`WORD_W-1:`WORD_W];
    assign zLow  = zReg[`WORD_W-1:0];

endmodule

// File: verilog/mdrUnit.sv
`timescale 1ns/10ps

module mdrUnit (
    input  logic                clock,
    input  logic                rst,
    input  busCpuPkg::word_t    busWord,
    input  busCpuPkg::word_t    mdataIn,
    input  busCpuPkg::regLoad_t regLoad,
    output busCpuPkg::word_t    mdr
);
    import busCpuPkg::*;

    word_t mdrNext;

    // Memory read data or a bus write value
    assign mdrNext = regLoad.read ? mdataIn : busWord;

    always_ff @(posedge clock) begin
        if (rst) begin
            mdr <= '0;
        end else if (regLoad.mdrIn) begin
            mdr <= mdrNext;
        end
    end

endmodule

// File: verilog/datapath.sv
`timescale 1ns/10ps
`include "busCpu_consts.svh"

module datapath (
    input  logic                clock,
    input  logic                rst,
    input  busCpuPkg::busSrc_t  busSrc,
    input  busCpuPkg::regLoad_t regLoad,
    input  busCpuPkg::opcode_t  opcode,
    input  busCpuPkg::word_t    mdataIn,
    input  busCpuPkg::word_t    inPortData,
    output busCpuPkg::word_t    busWord,
    output busCpuPkg::word_t    mar,
    output busCpuPkg::word_t    ir
);
    import busCpuPkg::*;

    word_t regs [`NUM_REGS];
    word_t hi;
    word_t lo;
    word_t zHigh;
    word_t zLow;
    word_t mdr;
    word_t pc;

    // Program counter, advanced through Z by the fetch sequence
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (regLoad.pcIn) begin
            pc <= busWord;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ir <= '0;
        end else if (regLoad.irIn) begin
            ir <= busWord;  // Instruction from MDR
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            mar <= '0;
        end else if (regLoad.marIn) begin
            mar <= busWord;  // Address to memory
        end
    end

    regFile regFile0 (
        .clock   (clock),
        .rst     (rst),
        .busWord (busWord),
        .regLoad (regLoad),
        .regs    (regs),
        .hi      (hi),
        .lo      (lo)
    );

    aluUnit aluUnit0 (
        .clock   (clock),
        .rst     (rst),
        .busWord (busWord),
        .opcode  (opcode),
        .regLoad (regLoad),
        .zHigh   (zHigh),
        .zLow    (zLow)
    );

    mdrUnit mdrUnit0 (
        .clock   (clock),
        .rst     (rst),
        .busWord (busWord),
        .mdataIn (mdataIn),
        .regLoad (regLoad),
        .mdr     (mdr)
    );

    // Single shared bus
    busMux busMux0 (
        .busSrc     (busSrc),
        .regs       (regs),
        .hi         (hi),
        .lo         (lo),
        .zHigh      (zHigh),
        .zLow       (zLow),
        .pc         (pc),
        .mdr        (mdr),
        .inPortData (inPortData),
        .ir         (ir),
        .busWord    (busWord)
    );

endmodule

// File: dv/datapathTb.sv
`timescale 1ns/10ps
`include "busCpu_consts.svh"

module datapathTb;
    import busCpuPkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int LOAD_TARGETS = 18;  // R0 to R15, HI, LO
    localparam int NUM_OPS      = 12;
    localparam int FETCHES      = 6;
    localparam int IMM_TESTS    = 4;
    localparam int PORT_TESTS   = 4;
    localparam int PLANNED_CYCLES = RESET_CYCLES + 3 + 3 * LOAD_TARGETS + 6 * NUM_OPS + 2
                                  + 3 * FETCHES + 3 * IMM_TESTS + 2 * PORT_TESTS;

    // Source and destination codes used by the stimulus tasks
    localparam int SRC_ZH = 18, SRC_ZL = 19, SRC_PC = 20, SRC_MDR = 21, SRC_IN = 22, SRC_C = 23;
    localparam int DST_NONE = -1, DST_PC = 18, DST_IR = 19, DST_MAR = 20, DST_MDR = 21;
    localparam int DST_Y = 22, DST_Z = 23;

    logic      clock;
    logic      rst;
    busSrc_t   busSrc;
    regLoad_t  regLoad;
    opcode_t   opcode;
    word_t     mdataIn;
    word_t     inPortData;
    word_t     busWord;
    word_t     mar;
    word_t     ir;

    // Scoreboard
    word_t regExp [LOAD_TARGETS];
    word_t pcExp, marExp, irExp, yExp, busExp;
    string checkMsg;
    logic  checking;

    opcode_t opList [NUM_OPS] = '{`OP_AND, `OP_ADD, `OP_SUB, `OP_OR, `OP_SHR, `OP_SHL,
                                  `OP_ROR, `OP_ROL, `OP_MUL, `OP_NEG, `OP_NOT, `OP_NOP};

    datapath dut0 (
        .clock      (clock),
        .rst        (rst),
        .busSrc     (busSrc),
        .regLoad    (regLoad),
        .opcode     (opcode),
        .mdataIn    (mdataIn),
        .inPortData (inPortData),
        .busWord    (busWord),
        .mar        (mar),
        .ir         (ir)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Expected {Z high, Z low} for A in Y and B on the bus
    function automatic logic [63:0] aluRef(opcode_t op, word_t a, word_t b, logic incPc);
        logic [4:0]         n;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        word_t              lowW;
        word_t              highW;
        n     = b[4:0];
        lowW  = '0;
        highW = '0;
        if (incPc) begin
            lowW = b + 32'd1;
        end else begin
            case (op)
                `OP_AND: lowW = a & b;
                `OP_ADD: lowW = a + b;
                `OP_SUB: lowW = a - b;
                `OP_OR:  lowW = a | b;
                `OP_SHR: lowW = a >> n;
                `OP_SHL: lowW = a << n;
                `OP_ROR: lowW = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
                `OP_ROL: lowW = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
                `OP_MUL: begin
                    sa = {{32{a[31]}}, a};
                    sb = {{32{b[31]}}, b};
                    {highW, lowW} = sa * sb;
                end
                `OP_NEG: lowW = ~b + 32'd1;
                `OP_NOT: lowW = ~b;
                default: lowW = '0;
            endcase
        end
        return {highW, lowW};
    endfunction

    function automatic busSrc_t sourceStrobe(int sel);
        busSrc_t s;
        s = '0;
        if (sel >= 0 && sel < 16) s.rOut[sel] = 1'b1;
        else if (sel == 16) s.hiOut = 1'b1;
        else if (sel == 17) s.loOut = 1'b1;
        else if (sel == SRC_ZH) s.zHighOut = 1'b1;
        else if (sel == SRC_ZL) s.zLowOut = 1'b1;
        else if (sel == SRC_PC) s.pcOut = 1'b1;
        else if (sel == SRC_MDR) s.mdrOut = 1'b1;
        else if (sel == SRC_IN) s.inPortOut = 1'b1;
        else if (sel == SRC_C) s.cOut = 1'b1;
        return s;
    endfunction

    function automatic regLoad_t loadStrobe(int dst);
        regLoad_t l;
        l = '0;
        if (dst >= 0 && dst < 16) l.rIn[dst] = 1'b1;
        else if (dst == 16) l.hiIn = 1'b1;
        else if (dst == 17) l.loIn = 1'b1;
        else if (dst == DST_PC) l.pcIn = 1'b1;
        else if (dst == DST_IR) l.irIn = 1'b1;
        else if (dst == DST_MAR) l.marIn = 1'b1;
        else if (dst == DST_MDR) l.mdrIn = 1'b1;
        else if (dst == DST_Y) l.yIn = 1'b1;
        else if (dst == DST_Z) l.zIn = 1'b1;
        return l;
    endfunction

    task automatic checkWord(input word_t actual, input word_t expected, input string message);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s (got %h, expected %h)", $time, message, actual,
                     expected);
            $display("Some tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // One bus cycle with strobes set after the falling edge and held through the rising edge
    task automatic runCycle(input busSrc_t src, input regLoad_t ld, input opcode_t op,
                            input word_t mdata, input word_t port, input word_t exp,
                            input string msg);
        @(negedge clock);
        busSrc     = src;
        regLoad    = ld;
        opcode     = op;
        mdataIn    = mdata;
        inPortData = port;
        busExp     = exp;
        checkMsg   = msg;
        checking   = 1'b1;
        @(posedge clock);
        #1;
    endtask

    task automatic transfer(input int src, input int dst, input word_t value, input string msg);
        runCycle(sourceStrobe(src), loadStrobe(dst), `OP_NOP, '0, '0, value, msg);
        if (dst >= 0 && dst < LOAD_TARGETS) regExp[dst] = value;
        else if (dst == DST_PC) pcExp = value;
        else if (dst == DST_IR) irExp = value;
        else if (dst == DST_MAR) marExp = value;
        else if (dst == DST_Y) yExp = value;
    endtask

    task automatic memLoad(input word_t value);
        regLoad_t ld;
        ld = loadStrobe(DST_MDR);
        ld.read = 1'b1;  // Memory side only so the bus stays idle
        runCycle('0, ld, `OP_NOP, value, '0, '0, "idle bus during MDR read");
    endtask

    // Samples one time step before each rising edge
    initial begin
        forever begin
            @(negedge clock);
            #(CLK_PERIOD / 2 - 1);
            if (checking) begin
                checkWord(busWord, busExp, checkMsg);
                checkWord(mar, marExp, "MAR contents");
                checkWord(ir, irExp, "IR contents");
            end
        end
    end

    initial begin
        #(PLANNED_CYCLES * CLK_PERIOD * 2);
        $display("The run timed out after %0d planned cycles", PLANNED_CYCLES);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          order [LOAD_TARGETS];
        int          j;
        int          tmp;
        word_t       value;
        word_t       a;
        word_t       b;
        logic [63:0] zPair;
        regLoad_t    ld;

        void'($urandom(48297));
        rst        = 1'b1;
        busSrc     = '0;
        regLoad    = '0;
        opcode     = `OP_NOP;
        mdataIn    = '0;
        inPortData = '0;
        checking   = 1'b0;
        busExp     = '0;
        pcExp      = '0;
        marExp     = '0;
        irExp      = '0;
        yExp       = '0;
        for (int i = 0; i < LOAD_TARGETS; i++) begin
            regExp[i] = '0;
            order[i]  = i;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        // Everything reads zero after reset
        transfer(0, DST_NONE, '0, "R0 after reset");
        transfer(SRC_PC, DST_NONE, '0, "PC after reset");
        transfer(SRC_ZL, DST_NONE, '0, "Z low after reset");

        // Shuffle the target order and then load and read back
        for (int i = LOAD_TARGETS - 1; i > 0; i--) begin
            j        = $urandom_range(i, 0);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < LOAD_TARGETS; i++) begin
            value = $urandom;
            memLoad(value);
            transfer(SRC_MDR, order[i], value, $sformatf("MDR to target %0d", order[i]));
        end
        for (int i = 0; i < LOAD_TARGETS; i++) begin
            transfer(i, DST_NONE, regExp[i], $sformatf("readback of target %0d", i));
        end

        for (int i = 0; i < NUM_OPS; i++) begin
            a = $urandom;
            b = $urandom;
            memLoad(a);
            transfer(SRC_MDR, DST_Y, a, "operand A into Y");
            memLoad(b);
            runCycle(sourceStrobe(SRC_MDR), loadStrobe(DST_Z), opList[i], '0, '0, b,
                     "operand B on bus");
            zPair = aluRef(opList[i], yExp, b, 1'b0);
            transfer(SRC_ZL, DST_NONE, zPair[31:0], $sformatf("Z low, opcode %b", opList[i]));
            transfer(SRC_ZH, DST_NONE, zPair[63:32], $sformatf("Z high, opcode %b", opList[i]));
        end

        // Fetch sequence from a random start address
        value = $urandom;
        memLoad(value);
        transfer(SRC_MDR, DST_PC, value, "PC start value");
        for (int i = 0; i < FETCHES; i++) begin
            ld = loadStrobe(DST_MAR);
            ld.zIn   = 1'b1;
            ld.incPc = 1'b1;
            runCycle(sourceStrobe(SRC_PC), ld, `OP_NOP, '0, '0, pcExp, "PC out for fetch");
            marExp = pcExp;
            zPair  = aluRef(`OP_NOP, yExp, pcExp, 1'b1);
            transfer(SRC_ZL, DST_PC, zPair[31:0], "PC plus one from Z");
            transfer(SRC_PC, DST_NONE, pcExp, "incremented PC");
        end

        for (int i = 0; i < IMM_TESTS; i++) begin
            value     = $urandom;
            value[18] = i[0];  // Both signs of the immediate
            memLoad(value);
            transfer(SRC_MDR, DST_IR, value, "instruction into IR");
            transfer(SRC_C, DST_NONE, {{13{value[18]}}, value[18:0]}, "sign-extended immediate");
        end

        for (int i = 0; i < PORT_TESTS; i++) begin
            value = $urandom;
            tmp   = $urandom_range(15, 0);
            runCycle(sourceStrobe(SRC_IN), loadStrobe(tmp), `OP_NOP, '0, value, value,
                     "input port on bus");
            regExp[tmp] = value;
            transfer(tmp, DST_NONE, regExp[tmp], $sformatf("R%0d from input port", tmp));
        end

        checking = 1'b0;
        $display("All tests passed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+verilog
verilog/busCpuPkg.sv
verilog/regFile.sv
verilog/busMux.sv
verilog/aluUnit.sv
verilog/mdrUnit.sv
verilog/datapath.sv
dv/datapathTb.sv
